/* sources.f */
source/bus_pkg.sv
source/bus_err_check.sv
source/bus_sink.sv
source/scratch_regs.sv
source/bus_demux.sv
source/bus_subsys_top.sv
bench/bus_subsys_tb.sv

/* Makefile */
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -j 0
TOP       ?= bus_subsys_tb
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build and run the testbench with Verilator"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TESTBENCH PASSED"

clean:
	rm -rf $(BUILD_DIR)

/* bench/bus_subsys_tb.sv */
//////////////////////////////
// Testbench for the peripheral slice
// Clock, reset, stimulus, reference model
// Response checks and reporting
//////////////////////////////
module bus_subsys_tb import bus_pkg::*; ();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int AddrW       = 12;
  localparam int NumRegs     = 4;
  localparam int IdxW        = (NumRegs > 1) ? $clog2(NumRegs) : 1;
  localparam int ResetCycles = 8;
  // Transactions over all tests
  localparam int NumTxn      = 66;
  // Worst case cycles per transaction with random stalls
  localparam int TxnBound    = 40;
  localparam int CycleLimit  = NumTxn * TxnBound + 2 * ResetCycles;
  localparam logic [AddrW-1:0] RegWindow = AddrW'(NumRegs * 4);
  localparam logic [AddrW-1:0] SinkBase  = AddrW'(12'h200);

  typedef struct packed {
    logic [2:0]       opcode;
    logic [SizeW-1:0] size;
    logic [SrcW-1:0]  source;
    logic [DataW-1:0] data;
    logic             error;
  } rsp_t;

  logic             clk_i;
  logic             rst_ni;
  logic             a_valid_i;
  bus_op_e          a_opcode_i;
  logic [SizeW-1:0] a_size_i;
  logic [AddrW-1:0] a_address_i;
  logic [StrbW-1:0] a_mask_i;
  logic [DataW-1:0] a_data_i;
  logic [SrcW-1:0]  a_source_i;
  logic             a_ready_o;
  logic             d_valid_o;
  bus_rsp_e         d_opcode_o;
  logic [SizeW-1:0] d_size_o;
  logic [SrcW-1:0]  d_source_o;
  logic [DataW-1:0] d_data_o;
  logic             d_error_o;
  logic             d_ready_i;

  logic [DataW-1:0] model_regs [NumRegs];
  rsp_t             exp_q [$];
  rsp_t             exp_rsp;
  int               seed = 45018;
  logic [31:0]      rnd;
  logic [31:0]      rnd_data;
  logic [31:0]      ready_rnd;
  logic             stall_en;
  int               errors;
  int               checks;
  int               issued;
  int               tests_run;
  int               err_mark;
  int               cycle_cnt;

  bus_subsys_top #(
    .AddrW   (AddrW),
    .NumRegs (NumRegs)
  ) dut_i (.*);

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  //////////////////////////////
  // Reference model
  //////////////////////////////

  // Computes the expected D beat for one accepted request and updates the model
  function automatic rsp_t model_access(input logic [2:0] op, input logic [SizeW-1:0] size,
                                        input logic [AddrW-1:0] addr,
                                        input logic [StrbW-1:0] mask,
                                        input logic [DataW-1:0] data,
                                        input logic [SrcW-1:0] src);
    rsp_t            r;
    logic [3:0]      lanes;
    logic            is_wr;
    logic            err;
    logic [IdxW-1:0] idx;
    is_wr = (op == 3'd0) || (op == 3'd1);
    // Lanes touched by size and byte offset
    case (size)
      2'd0:    lanes = 4'b0001 << addr[1:0];
      2'd1:    lanes = addr[1] ? 4'b1100 : 4'b0011;
      2'd2:    lanes = 4'b1111;
      default: lanes = 4'b0000;
    endcase
    err = !(is_wr || op == 3'd4) || (size == 2'd3);
    if ((size == 2'd1 && addr[0]) || (size == 2'd2 && addr[1:0] != 2'b00)) err = 1'b1;
    if (op == 3'd0 && mask != lanes) err = 1'b1;
    if (op == 3'd1 && (mask & ~lanes) != 4'b0000) err = 1'b1;
    r.opcode = (op == 3'd4) ? 3'd1 : 3'd0;
    r.size   = size;
    r.source = src;
    r.data   = '0;
    if (addr < RegWindow) begin
      idx = addr[IdxW+1:2];
      if (!err && is_wr) begin
        for (int b = 0; b < StrbW; b++) begin
          if (mask[b]) model_regs[idx][8*b +: 8] = data[8*b +: 8];
        end
      end else if (!err && op == 3'd4) begin
        r.data = model_regs[idx];
      end
    end else if (is_wr && (addr[1:0] != 2'b00 || mask != 4'hF)) begin
      // Sink takes full aligned words only
      err = 1'b1;
    end
    r.error = err;
    return r;
  endfunction

  //////////////////////////////
  // Monitor and compare
  //////////////////////////////

  // Sampled mid-cycle before the transfer edge
  always @(negedge clk_i) begin
    if (rst_ni) begin
      if (d_valid_o && d_ready_i) begin
        assert (exp_q.size() != 0) else begin
          $display("ERROR at %0t: response seen with no request outstanding", $time);
          errors++;
        end
        if (exp_q.size() != 0) begin
          exp_rsp = exp_q.pop_front();
          checks++;
          assert (d_opcode_o == exp_rsp.opcode) else begin
            $display("MISMATCH at %0t: opcode %0d, expected %0d", $time, d_opcode_o,
                     exp_rsp.opcode);
            errors++;
          end
          assert (d_size_o == exp_rsp.size && d_source_o == exp_rsp.source) else begin
            $display("MISMATCH at %0t: size/source %0d/%0h, expected %0d/%0h", $time,
                     d_size_o, d_source_o, exp_rsp.size, exp_rsp.source);
            errors++;
          end
          assert (d_data_o === exp_rsp.data) else begin
            $display("MISMATCH at %0t: data %h, expected %h", $time, d_data_o, exp_rsp.data);
            errors++;
          end
          assert (d_error_o === exp_rsp.error) else begin
            $display("MISMATCH at %0t: error %b, expected %b", $time, d_error_o,
                     exp_rsp.error);
            errors++;
          end
        end
      end
      if (a_valid_i && a_ready_o) begin
        // One outstanding request at most
        assert (exp_q.size() == 0 && !d_valid_o) else begin
          $display("ERROR at %0t: request accepted while a response is outstanding", $time);
          errors++;
        end
        exp_q.push_back(model_access(a_opcode_i, a_size_i, a_address_i, a_mask_i,
                                     a_data_i, a_source_i));
      end
    end
  end

  // Random D back-pressure when enabled
  always @(posedge clk_i) begin
    #2;
    if (stall_en) begin
      ready_rnd = $random(seed);
      d_ready_i = ready_rnd[0];
    end else begin
      d_ready_i = 1'b1;
    end
  end

  always @(posedge clk_i) begin
    cycle_cnt++;
    if (cycle_cnt > CycleLimit) begin
      $display("ERROR: run did not finish within %0d cycles, timeout", CycleLimit);
      $display("TESTBENCH FAILED");
      $finish;
    end
  end

  //////////////////////////////
  // Stimulus tasks
  //////////////////////////////

  // Runs from just after a rising edge to just after the accepting edge
  task automatic issue(input bus_op_e op, input logic [SizeW-1:0] size,
                       input logic [AddrW-1:0] addr, input logic [StrbW-1:0] mask,
                       input logic [DataW-1:0] data, input logic [SrcW-1:0] src);
    a_valid_i   = 1'b1;
    a_opcode_i  = op;
    a_size_i    = size;
    a_address_i = addr;
    a_mask_i    = mask;
    a_data_i    = data;
    a_source_i  = src;
    do @(negedge clk_i); while (!a_ready_o);
    @(posedge clk_i);
    #2;
    a_valid_i = 1'b0;
    issued++;
  endtask

  task automatic read_all();
    for (int i = 0; i < NumRegs; i++) begin
      issue(Get, 2'd2, AddrW'(i * 4), 4'hF, '0, SrcW'(i));
    end
  endtask

  // Drains responses and reports the test
  task automatic finish_test(input string name, input int err_before);
    while (exp_q.size() != 0 || d_valid_o) @(negedge clk_i);
    @(posedge clk_i);
    #2;
    tests_run++;
    if (errors == err_before) $display("test %0d %s: ok", tests_run, name);
    else $display("test %0d %s: %0d errors", tests_run, name, errors - err_before);
  endtask

  task automatic apply_reset();
    rst_ni = 1'b0;
    repeat (ResetCycles) @(posedge clk_i);
    #2;
    rst_ni = 1'b1;
    for (int i = 0; i < NumRegs; i++) model_regs[i] = '0;
    // Responses still owed at reset are dropped
    issued -= exp_q.size();
    exp_q.delete();
  endtask

  //////////////////////////////
  // Test sequence
  //////////////////////////////

  initial begin
    rst_ni      = 1'b0;
    a_valid_i   = 1'b0;
    a_opcode_i  = PutFullData;
    a_size_i    = '0;
    a_address_i = '0;
    a_mask_i    = '0;
    a_data_i    = '0;
    a_source_i  = '0;
    d_ready_i   = 1'b1;
    stall_en    = 1'b0;
    errors      = 0;
    checks      = 0;
    issued      = 0;
    tests_run   = 0;
    cycle_cnt   = 0;
    @(posedge clk_i);
    #2;
    apply_reset();

    // Full words into each register and read back
    err_mark = errors;
    for (int i = 0; i < NumRegs; i++) begin
      rnd = $random(seed);
      issue(PutFullData, 2'd2, AddrW'(i * 4), 4'hF, rnd, SrcW'(i));
    end
    read_all();
    finish_test("full word writes", err_mark);

    // Random masks followed by sub-word reads
    err_mark = errors;
    for (int i = 0; i < NumRegs; i++) begin
      rnd      = $random(seed);
      rnd_data = $random(seed);
      issue(PutPartialData, 2'd2, AddrW'(i * 4), rnd[3:0], rnd_data, rnd[7:4]);
      issue(Get, 2'd2, AddrW'(i * 4), 4'hF, '0, rnd[11:8]);
    end
    for (int i = 0; i < NumRegs; i++) begin
      rnd = $random(seed);
      issue(Get, 2'd0, AddrW'(i * 4) + AddrW'(rnd[1:0]), 4'b0001 << rnd[1:0], '0, rnd[7:4]);
      issue(Get, 2'd1, AddrW'(i * 4) + AddrW'({rnd[2], 1'b0}), rnd[2] ? 4'hC : 4'h3, '0,
            rnd[11:8]);
    end
    finish_test("partial writes", err_mark);

    // Illegal accesses in the window leave registers alone
    err_mark = errors;
    issue(bus_op_e'(3'd2), 2'd2, AddrW'(4), 4'hF, 32'hDEAD_0001, 4'h1);
    issue(PutFullData, 2'd3, AddrW'(4), 4'hF, 32'hDEAD_0002, 4'h2);
    issue(PutFullData, 2'd2, AddrW'(6), 4'hF, 32'hDEAD_0003, 4'h3);
    issue(PutFullData, 2'd2, AddrW'(4), 4'h7, 32'hDEAD_0004, 4'h4);
    read_all();
    finish_test("illegal accesses", err_mark);

    // Unmapped space goes to the sink
    err_mark = errors;
    issue(Get, 2'd2, SinkBase, 4'hF, '0, 4'h5);
    issue(Get, 2'd2, SinkBase + AddrW'(12'h104), 4'hF, '0, 4'h6);
    issue(PutFullData, 2'd2, SinkBase, 4'hF, 32'h1234_5678, 4'h7);
    issue(PutPartialData, 2'd2, SinkBase + AddrW'(4), 4'h3, 32'h1111_2222, 4'h8);
    issue(PutFullData, 2'd0, SinkBase + AddrW'(1), 4'h2, 32'h3333_4444, 4'h9);
    finish_test("sink accesses", err_mark);

    // Random mix under D back-pressure
    err_mark = errors;
    stall_en = 1'b1;
    for (int n = 0; n < 24; n++) begin
      rnd      = $random(seed);
      rnd_data = $random(seed);
      a_address_i = AddrW'({rnd[5:4], 2'b00});
      if (rnd[2]) a_address_i = a_address_i + SinkBase;
      case (rnd[1:0])
        2'd0:    issue(PutFullData, 2'd2, a_address_i, 4'hF, rnd_data, rnd[15:12]);
        2'd1:    issue(PutPartialData, 2'd2, a_address_i, rnd[11:8], rnd_data, rnd[15:12]);
        default: issue(Get, 2'd2, a_address_i, 4'hF, '0, rnd[15:12]);
      endcase
    end
    finish_test("back-pressure", err_mark);
    stall_en = 1'b0;

    // Reset hits while a read response is still owed
    err_mark = errors;
    issue(Get, 2'd2, AddrW'(0), 4'hF, '0, 4'hA);
    apply_reset();
    assert (!d_valid_o && a_ready_o) else begin
      $display("MISMATCH at %0t: handshake outputs not idle after reset", $time);
      errors++;
    end
    read_all();
    finish_test("reset values", err_mark);

    assert (checks == issued) else begin
      $display("ERROR: %0d requests issued but %0d responses checked", issued, checks);
      errors++;
    end
    $display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

/* source/bus_subsys_top.sv */
//////////////////////////////
// Peripheral slice top level
// Demultiplexer, register block and sink
//////////////////////////////
module bus_subsys_top import bus_pkg::*; #(
  parameter int AddrW   = 12,
  parameter int NumRegs = 4
) (
  input  logic             clk_i,
  input  logic             rst_ni,
  // Channel A from host
  input  logic             a_valid_i,
  input  bus_op_e          a_opcode_i,
  input  logic [SizeW-1:0] a_size_i,
  input  logic [AddrW-1:0] a_address_i,
  input  logic [StrbW-1:0] a_mask_i,
  input  logic [DataW-1:0] a_data_i,
  input  logic [SrcW-1:0]  a_source_i,
  output logic             a_ready_o,
  // Channel D to host
  output logic             d_valid_o,
  output bus_rsp_e         d_opcode_o,
  output logic [SizeW-1:0] d_size_o,
  output logic [SrcW-1:0]  d_source_o,
  output logic [DataW-1:0] d_data_o,
  output logic             d_error_o,
  input  logic             d_ready_i
);
  // Register block side
  logic             reg_a_valid;
  logic             reg_a_ready;
  logic             reg_d_valid;
  bus_rsp_e         reg_d_opcode;
  logic [SizeW-1:0] reg_d_size;
  logic [SrcW-1:0]  reg_d_source;
  logic [DataW-1:0] reg_d_data;
  logic             reg_d_error;
  logic             reg_d_ready;

  // Sink side
  logic             sink_a_valid;
  logic             sink_a_ready;
  logic             sink_d_valid;
  bus_rsp_e         sink_d_opcode;
  logic [SizeW-1:0] sink_d_size;
  logic [SrcW-1:0]  sink_d_source;
  logic [DataW-1:0] sink_d_data;
  logic             sink_d_error;
  logic             sink_d_ready;

  bus_demux #(
    .AddrW   (AddrW),
    .NumRegs (NumRegs)
  ) u_demux (
    .clk_i,
    .rst_ni,
    .a_valid_i,
    .a_address_i,
    .a_ready_o,
    .d_valid_o,
    .d_opcode_o,
    .d_size_o,
    .d_source_o,
    .d_data_o,
    .d_error_o,
    .d_ready_i,
    .reg_a_valid_o   (reg_a_valid),
    .reg_a_ready_i   (reg_a_ready),
    .reg_d_valid_i   (reg_d_valid),
    .reg_d_opcode_i  (reg_d_opcode),
    .reg_d_size_i    (reg_d_size),
    .reg_d_source_i  (reg_d_source),
    .reg_d_data_i    (reg_d_data),
    .reg_d_error_i   (reg_d_error),
    .reg_d_ready_o   (reg_d_ready),
    .sink_a_valid_o  (sink_a_valid),
    .sink_a_ready_i  (sink_a_ready),
    .sink_d_valid_i  (sink_d_valid),
    .sink_d_opcode_i (sink_d_opcode),
    .sink_d_size_i   (sink_d_size),
    .sink_d_source_i (sink_d_source),
    .sink_d_data_i   (sink_d_data),
    .sink_d_error_i  (sink_d_error),
    .sink_d_ready_o  (sink_d_ready)
  );

  // A fields fan out unchanged, only valid is steered
  scratch_regs #(
    .AddrW   (AddrW),
    .NumRegs (NumRegs)
  ) u_regs (
    .clk_i,
    .rst_ni,
    .a_valid_i  (reg_a_valid),
    .a_opcode_i,
    .a_size_i,
    .a_address_i,
    .a_mask_i,
    .a_data_i,
    .a_source_i,
    .a_ready_o  (reg_a_ready),
    .d_valid_o  (reg_d_valid),
    .d_opcode_o (reg_d_opcode),
    .d_size_o   (reg_d_size),
    .d_source_o (reg_d_source),
    .d_data_o   (reg_d_data),
    .d_error_o  (reg_d_error),
    .d_ready_i  (reg_d_ready)
  );

  bus_sink #(
    .AddrW (AddrW)
  ) u_sink (
    .clk_i,
    .rst_ni,
    .a_valid_i  (sink_a_valid),
    .a_opcode_i,
    .a_size_i,
    .a_address_i,
    .a_mask_i,
    .a_source_i,
    .a_ready_o  (sink_a_ready),
    .d_valid_o  (sink_d_valid),
    .d_opcode_o (sink_d_opcode),
    .d_size_o   (sink_d_size),
    .d_source_o (sink_d_source),
    .d_data_o   (sink_d_data),
    .d_error_o  (sink_d_error),
    .d_ready_i  (sink_d_ready)
  );

endmodule

/* source/bus_demux.sv */
//////////////////////////////
// Request demultiplexer
// Address decode, per-target valid and ready
// Single outstanding request, response return mux
//////////////////////////////
module bus_demux import bus_pkg::*; #(
  parameter int AddrW   = 12,
  parameter int NumRegs = 4
) (
  input  logic             clk_i,
  input  logic             rst_ni,
  // Host side
  input  logic             a_valid_i,
  input  logic [AddrW-1:0] a_address_i,
  output logic             a_ready_o,
  output logic             d_valid_o,
  output bus_rsp_e         d_opcode_o,
  output logic [SizeW-1:0] d_size_o,
  output logic [SrcW-1:0]  d_source_o,
  output logic [DataW-1:0] d_data_o,
  output logic             d_error_o,
  input  logic             d_ready_i,
  // Register block
  output logic             reg_a_valid_o,
  input  logic             reg_a_ready_i,
  input  logic             reg_d_valid_i,
  input  bus_rsp_e         reg_d_opcode_i,
  input  logic [SizeW-1:0] reg_d_size_i,
  input  logic [SrcW-1:0]  reg_d_source_i,
  input  logic [DataW-1:0] reg_d_data_i,
  input  logic             reg_d_error_i,
  output logic             reg_d_ready_o,
  // Sink
  output logic             sink_a_valid_o,
  input  logic             sink_a_ready_i,
  input  logic             sink_d_valid_i,
  input  bus_rsp_e         sink_d_opcode_i,
  input  logic [SizeW-1:0] sink_d_size_i,
  input  logic [SrcW-1:0]  sink_d_source_i,
  input  logic [DataW-1:0] sink_d_data_i,
  input  logic             sink_d_error_i,
  output logic             sink_d_ready_o
);
  // End of register window, exclusive
  localparam logic [AddrW:0] RegLimit = (AddrW+1)'(NumRegs * 4);

  logic sel_reg;
  logic outstanding_q;
  logic tgt_reg_q;
  logic a_ack;
  logic d_ack;

  //////////////////////////////
  // Request steering
  //////////////////////////////

  assign sel_reg = ({1'b0, a_address_i} < RegLimit);

  // No new request while a response is owed
  assign reg_a_valid_o  = a_valid_i & ~outstanding_q & sel_reg;
  assign sink_a_valid_o = a_valid_i & ~outstanding_q & ~sel_reg;
  assign a_ready_o      = ~outstanding_q & (sel_reg ? reg_a_ready_i : sink_a_ready_i);

  assign a_ack = a_valid_i & a_ready_o;
  assign d_ack = d_valid_o & d_ready_i;

  // Remember who owes the response
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      outstanding_q <= 1'b0;
      tgt_reg_q     <= 1'b0;
    end else if (a_ack) begin
      outstanding_q <= 1'b1;
      tgt_reg_q     <= sel_reg;
    end else if (d_ack) begin
      outstanding_q <= 1'b0;
    end
  end

  //////////////////////////////
  // Response return
  //////////////////////////////

  assign d_valid_o = outstanding_q & (tgt_reg_q ? reg_d_valid_i : sink_d_valid_i);

  // Ready goes back to the recorded target only
  assign reg_d_ready_o  = outstanding_q & tgt_reg_q & d_ready_i;
  assign sink_d_ready_o = outstanding_q & ~tgt_reg_q & d_ready_i;

  assign d_opcode_o = tgt_reg_q ? reg_d_opcode_i : sink_d_opcode_i;
  assign d_size_o   = tgt_reg_q ? reg_d_size_i   : sink_d_size_i;
  assign d_source_o = tgt_reg_q ? reg_d_source_i : sink_d_source_i;
  assign d_data_o   = tgt_reg_q ? reg_d_data_i   : sink_d_data_i;
  assign d_error_o  = tgt_reg_q ? reg_d_error_i  : sink_d_error_i;

endmodule

/* source/scratch_regs.sv */
//////////////////////////////
// Scratch register block
// Word registers, byte-masked writes
// Read-back responses, one deep
//////////////////////////////
module scratch_regs import bus_pkg::*; #(
  parameter int AddrW   = 12,
  parameter int NumRegs = 4
) (
  input  logic             clk_i,
  input  logic             rst_ni,
  // Channel A
  input  logic             a_valid_i,
  input  bus_op_e          a_opcode_i,
  input  logic [SizeW-1:0] a_size_i,
  input  logic [AddrW-1:0] a_address_i,
  input  logic [StrbW-1:0] a_mask_i,
  input  logic [DataW-1:0] a_data_i,
  input  logic [SrcW-1:0]  a_source_i,
  output logic             a_ready_o,
  // Channel D
  output logic             d_valid_o,
  output bus_rsp_e         d_opcode_o,
  output logic [SizeW-1:0] d_size_o,
  output logic [SrcW-1:0]  d_source_o,
  output logic [DataW-1:0] d_data_o,
  output logic             d_error_o,
  input  logic             d_ready_i
);
  // Word index bits, at least one
  localparam int IdxW = (NumRegs > 1) ? $clog2(NumRegs) : 1;
  localparam logic [AddrW-3:0] WordLimit = (AddrW-2)'(NumRegs);

  logic [DataW-1:0] regs_q [NumRegs];
  logic             pending_q;
  logic             a_ack;
  logic             d_ack;
  logic             wr_req;
  logic             rd_req;
  logic             chk_err;
  logic             in_range;
  logic             acc_err;
  logic [IdxW-1:0]  word_idx;
  logic [SrcW-1:0]  d_source_q;
  logic [SizeW-1:0] d_size_q;
  bus_rsp_e         d_opcode_q;
  logic [DataW-1:0] d_data_q;
  logic             d_error_q;

  assign a_ack  = a_valid_i & ~pending_q;
  assign d_ack  = pending_q & d_ready_i;
  assign wr_req = (a_opcode_i == PutFullData) | (a_opcode_i == PutPartialData);
  assign rd_req = (a_opcode_i == Get);

  // Word select from byte address
  assign word_idx = a_address_i[IdxW+1:2];
  // Guards non power-of-two register counts
  assign in_range = (a_address_i[AddrW-1:2] < WordLimit);

  bus_err_check u_err_check (
    .a_opcode_i  (a_opcode_i),
    .a_size_i    (a_size_i),
    .a_address_i (a_address_i[1:0]),
    .a_mask_i    (a_mask_i),
    .err_o       (chk_err)
  );

  assign acc_err = chk_err | ~in_range;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pending_q <= 1'b0;
    end else if (a_ack) begin
      pending_q <= 1'b1;
    end else if (d_ack) begin
      pending_q <= 1'b0;
    end
  end

  //////////////////////////////
  // Register array
  //////////////////////////////

  // Written on the acceptance edge, masked bytes only
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < NumRegs; i++) begin
        regs_q[i] <= '0;
      end
    end else if (a_ack && wr_req && !acc_err) begin
      for (int b = 0; b < StrbW; b++) begin
        if (a_mask_i[b]) begin
          regs_q[word_idx][8*b +: 8] <= a_data_i[8*b +: 8];
        end
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      d_error_q <= 1'b0;
    end else if (a_ack) begin
      d_error_q <= acc_err;
    end
  end

  // Response payload, zero data on error
  always_ff @(posedge clk_i) begin
    if (a_ack) begin
      d_source_q <= a_source_i;
      d_size_q   <= a_size_i;
      d_opcode_q <= rd_req ? AccessAckData : AccessAck;
      d_data_q   <= (rd_req && !acc_err) ? regs_q[word_idx] : '0;
    end
  end

  assign a_ready_o  = ~pending_q;
  assign d_valid_o  = pending_q;
  assign d_opcode_o = d_opcode_q;
  assign d_size_o   = d_size_q;
  assign d_source_o = d_source_q;
  assign d_data_o   = d_data_q;
  assign d_error_o  = d_error_q;

endmodule

/* source/bus_sink.sv */
//////////////////////////////
// Bus sink for unmapped space
// One-deep response register with error flag
//////////////////////////////
module bus_sink import bus_pkg::*; #(
  parameter int AddrW = 12
) (
  input  logic             clk_i,
  input  logic             rst_ni,
  // Channel A
  input  logic             a_valid_i,
  input  bus_op_e          a_opcode_i,
  input  logic [SizeW-1:0] a_size_i,
  input  logic [AddrW-1:0] a_address_i,
  input  logic [StrbW-1:0] a_mask_i,
  input  logic [SrcW-1:0]  a_source_i,
  output logic             a_ready_o,
  // Channel D
  output logic             d_valid_o,
  output bus_rsp_e         d_opcode_o,
  output logic [SizeW-1:0] d_size_o,
  output logic [SrcW-1:0]  d_source_o,
  output logic [DataW-1:0] d_data_o,
  output logic             d_error_o,
  input  logic             d_ready_i
);
  logic             pending_q;
  logic             a_ack;
  logic             d_ack;
  logic             wr_req;
  logic             rd_req;
  logic             align_err;
  logic             mask_err;
  logic             chk_err;
  logic [SrcW-1:0]  d_source_q;
  logic [SizeW-1:0] d_size_q;
  bus_rsp_e         d_opcode_q;
  logic             d_error_q;

  assign a_ack  = a_valid_i & ~pending_q;
  assign d_ack  = pending_q & d_ready_i;
  assign wr_req = (a_opcode_i == PutFullData) | (a_opcode_i == PutPartialData);
  assign rd_req = (a_opcode_i == Get);

  // Busy from acceptance until the response leaves
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pending_q <= 1'b0;
    end else if (a_ack) begin
      pending_q <= 1'b1;
    end else if (d_ack) begin
      pending_q <= 1'b0;
    end
  end

  //////////////////////////////
  // Error handling
  //////////////////////////////

  // Sink takes word writes only, full mask
  assign align_err = wr_req & (|a_address_i[1:0]);
  assign mask_err  = wr_req & ~(&a_mask_i);

  bus_err_check u_err_check (
    .a_opcode_i  (a_opcode_i),
    .a_size_i    (a_size_i),
    .a_address_i (a_address_i[1:0]),
    .a_mask_i    (a_mask_i),
    .err_o       (chk_err)
  );

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      d_error_q <= 1'b0;
    end else if (a_ack) begin
      d_error_q <= align_err | mask_err | chk_err;
    end
  end

  // Response payload
  always_ff @(posedge clk_i) begin
    if (a_ack) begin
      d_source_q <= a_source_i;
      d_size_q   <= a_size_i;
      d_opcode_q <= rd_req ? AccessAckData : AccessAck;
    end
  end

  assign a_ready_o  = ~pending_q;
  assign d_valid_o  = pending_q;
  assign d_opcode_o = d_opcode_q;
  assign d_size_o   = d_size_q;
  assign d_source_o = d_source_q;
  // Unmapped space reads as zero
  assign d_data_o   = '0;
  assign d_error_o  = d_error_q;

endmodule

/* source/bus_err_check.sv */
//////////////////////////////
// Protocol legality checker
// Opcode, size, alignment and mask rules
//////////////////////////////
module bus_err_check import bus_pkg::*; (
  input  bus_op_e          a_opcode_i,
  input  logic [SizeW-1:0] a_size_i,
  input  logic [1:0]       a_address_i,
  input  logic [StrbW-1:0] a_mask_i,
  output logic             err_o
);
  logic [StrbW-1:0] lane_mask;
  logic             op_err;
  logic             size_err;
  logic             align_err;
  logic             mask_err;

  // Byte lanes covered by size and low address bits
  always_comb begin
    case (a_size_i)
      2'd0:    lane_mask = {{(StrbW-1){1'b0}}, 1'b1} << a_address_i;
      2'd1:    lane_mask = a_address_i[1] ? 4'b1100 : 4'b0011;
      2'd2:    lane_mask = '1;
      default: lane_mask = '0;
    endcase
  end

  // Only the three supported codes
  always_comb begin
    case (a_opcode_i)
      PutFullData, PutPartialData, Get: op_err = 1'b0;
      default:                          op_err = 1'b1;
    endcase
  end

  // Nothing wider than one word
  assign size_err = (a_size_i > 2'd2);

  // Address must be a multiple of the transfer size
  always_comb begin
    case (a_size_i)
      2'd1:    align_err = a_address_i[0];
      2'd2:    align_err = |a_address_i;
      default: align_err = 1'b0;
    endcase
  end

  // Full puts need the exact lanes, partial puts stay inside them
  always_comb begin
    case (a_opcode_i)
      PutFullData:    mask_err = (a_mask_i != lane_mask);
      PutPartialData: mask_err = |(a_mask_i & ~lane_mask);
      default:        mask_err = 1'b0;
    endcase
  end

  assign err_o = op_err | size_err | align_err | mask_err;

endmodule

/* source/bus_pkg.sv */
//////////////////////////////
// Bus package
// Fixed widths of the peripheral bus
// Channel A and channel D opcode encodings
//////////////////////////////
package bus_pkg;

  //////////////////////////////
  // Fixed bus widths
  //////////////////////////////

  // Data word, one full register
  localparam int DataW = 32;

  // One mask bit per data byte
  localparam int StrbW = DataW / 8;

  // Source tag, echoed back on D
  localparam int SrcW = 4;

  // Size field holds log2 of the byte count
  localparam int SizeW = 2;

  //////////////////////////////
  // Opcodes
  //////////////////////////////

  // Channel A requests, other codes illegal
  typedef enum logic [2:0] {
    PutFullData    = 3'd0,
    PutPartialData = 3'd1,
    Get            = 3'd4
  } bus_op_e;

  // Channel D responses
  typedef enum logic [2:0] {
    AccessAck     = 3'd0,
    AccessAckData = 3'd1
  } bus_rsp_e;

endpackage
